/* verilog/rob_settings.svh */
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// buffer geometry
`define ROB_SIZE_LOG 3
`define ROB_SIZE     8

// instruction payload widths
`define PC_WIDTH     64
`define INSTR_WIDTH  32

// rename fields
`define LREG_WIDTH   5
`define PREG_WIDTH   6

`endif

/* verilog/uop_pkg.sv */
`include "rob_settings.svh"

package uop_pkg;

    // 96 bit pc plus raw instruction word
    typedef struct packed {
        logic [`PC_WIDTH-1:0]    pc;
        logic [`INSTR_WIDTH-1:0] instr;
    } instr_info_t;

    // 18 bit destination mapping
    // old_prd is freed when the instruction retires
    typedef struct packed {
        logic [`LREG_WIDTH-1:0] lrd;
        logic [`PREG_WIDTH-1:0] prd;
        logic [`PREG_WIDTH-1:0] old_prd;
        logic                   need_to_wb;
    } rename_info_t;

endpackage

/* verilog/rob_pkg.sv */
`include "rob_settings.svh"

package rob_pkg;

    // slot number inside the buffer
    typedef logic [`ROB_SIZE_LOG-1:0] rob_idx_t;

    // pointer with wrap flag
    // same idx with different flag means full
    typedef struct packed {
        logic     flag;
        rob_idx_t idx;
    } rob_ptr_t;

endpackage

/* verilog/rob_ifs.sv */
`timescale 1ns/1ps

// payload store access with one write and one async read
interface rob_ram_if #(
    parameter type payload_t = logic
);
    import rob_pkg::*;

    logic     write_en;
    rob_idx_t write_idx;
    payload_t write_data;
    rob_idx_t read_idx;
    payload_t read_data;

    modport ctrl (
        output write_en,
        output write_idx,
        output write_data,
        output read_idx,
        input  read_data
    );

    modport ram (
        input  write_en,
        input  write_idx,
        input  write_data,
        input  read_idx,
        output read_data
    );
endinterface

// entry status bookkeeping between controller and status table
interface rob_status_if;
    import rob_pkg::*;

    logic     alloc_en;
    rob_idx_t alloc_idx;
    logic     retire_en;
    rob_idx_t head_idx;
    logic     head_valid;
    logic     head_complete;
    logic     head_skip;

    modport ctrl (
        output alloc_en,
        output alloc_idx,
        output retire_en,
        output head_idx,
        input  head_valid,
        input  head_complete,
        input  head_skip
    );

    modport tbl (
        input  alloc_en,
        input  alloc_idx,
        input  retire_en,
        input  head_idx,
        output head_valid,
        output head_complete,
        output head_skip
    );
endinterface

/* verilog/rob_payload_ram.sv */
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_payload_ram #(
    parameter type payload_t = uop_pkg::instr_info_t
) (
    input logic   clock,
    rob_ram_if.ram ram
);

    // one slot per rob entry
    payload_t mem [`ROB_SIZE];

    // written at enqueue time only
    always_ff @(posedge clock) begin
        if (ram.write_en) begin
            mem[ram.write_idx] <= ram.write_data;
        end
    end

    // async read
    // a same-cycle write to the same slot still shows old data
    assign ram.read_data = mem[ram.read_idx];

endmodule

/* verilog/rob_status_table.sv */
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_status_table (
    input logic              clock,
    input logic              reset_n,
    rob_status_if.tbl        status,
    input logic              wb0_valid,
    input rob_pkg::rob_idx_t wb0_robidx,
    input logic              wb1_valid,
    input rob_pkg::rob_idx_t wb1_robidx,
    input logic              wb1_mmio
);
    import rob_pkg::*;

    logic [`ROB_SIZE-1:0] valid_q;
    logic [`ROB_SIZE-1:0] complete_q;
    logic [`ROB_SIZE-1:0] skip_q;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_q    <= '0;
            complete_q <= '0;
            skip_q     <= '0;
        end else begin
            for (int i = 0; i < `ROB_SIZE; i++) begin
                if (status.alloc_en && status.alloc_idx == rob_idx_t'(i)) begin
                    // fresh entry waits for its writeback
                    valid_q[i]    <= 1'b1;
                    complete_q[i] <= 1'b0;
                    skip_q[i]     <= 1'b0;
                end else begin
                    if (status.retire_en && status.head_idx == rob_idx_t'(i)) begin
                        valid_q[i] <= 1'b0;
                    end
                    if (wb0_valid && wb0_robidx == rob_idx_t'(i)) begin
                        complete_q[i] <= 1'b1;
                    end
                    // only the load/store port can report mmio
                    if (wb1_valid && wb1_robidx == rob_idx_t'(i)) begin
                        complete_q[i] <= 1'b1;
                        if (wb1_mmio) begin
                            skip_q[i] <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // head lookup
    assign status.head_valid    = valid_q[status.head_idx];
    assign status.head_complete = complete_q[status.head_idx];
    assign status.head_skip     = skip_q[status.head_idx];

endmodule

/* verilog/rob_commit_ctrl.sv */
`timescale 1ns/1ps

module rob_commit_ctrl (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              enq_valid,
    output logic              enq_ready,
    output rob_pkg::rob_idx_t enq_robidx,
    output logic              commit_valid,
    input  logic              commit_ready,
    rob_status_if.ctrl        status,
    rob_ram_if.ctrl           info_ram,
    rob_ram_if.ctrl           rename_ram
);
    import rob_pkg::*;

    rob_ptr_t enq_ptr;
    rob_ptr_t deq_ptr;
    logic     full;
    logic     enq_fire;
    logic     commit_fire;

    // pointers meet on the same slot but one lap apart
    assign full = (enq_ptr.idx == deq_ptr.idx) && (enq_ptr.flag != deq_ptr.flag);

    assign enq_ready   = !full;
    assign enq_fire    = enq_valid && enq_ready;
    assign commit_valid = status.head_valid && status.head_complete;
    assign commit_fire = commit_valid && commit_ready;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            enq_ptr <= '0;
        end else if (enq_fire) begin
            enq_ptr <= enq_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            deq_ptr <= '0;
        end else if (commit_fire) begin
            deq_ptr <= deq_ptr + 1'b1;
        end
    end

    // next free slot handed back to dispatch
    assign enq_robidx = enq_ptr.idx;

    // status side
    assign status.alloc_en  = enq_fire;
    assign status.alloc_idx = enq_ptr.idx;
    assign status.retire_en = commit_fire;
    assign status.head_idx  = deq_ptr.idx;

    // both payload stores follow the same pointers
    assign info_ram.write_en    = enq_fire;
    assign info_ram.write_idx   = enq_ptr.idx;
    assign info_ram.read_idx    = deq_ptr.idx;
    assign rename_ram.write_en  = enq_fire;
    assign rename_ram.write_idx = enq_ptr.idx;
    assign rename_ram.read_idx  = deq_ptr.idx;

endmodule

/* verilog/rob_top.sv */
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_top (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     enq_valid,
    output logic                     enq_ready,
    input  logic [`PC_WIDTH-1:0]     enq_pc,
    input  logic [`INSTR_WIDTH-1:0]  enq_instr,
    input  logic [`LREG_WIDTH-1:0]   enq_lrd,
    input  logic [`PREG_WIDTH-1:0]   enq_prd,
    input  logic [`PREG_WIDTH-1:0]   enq_old_prd,
    input  logic                     enq_need_to_wb,
    output logic [`ROB_SIZE_LOG-1:0] enq_robidx,
    input  logic                     wb0_valid,
    input  logic [`ROB_SIZE_LOG-1:0] wb0_robidx,
    input  logic                     wb1_valid,
    input  logic [`ROB_SIZE_LOG-1:0] wb1_robidx,
    input  logic                     wb1_mmio,
    output logic                     commit_valid,
    input  logic                     commit_ready,
    output logic [`PC_WIDTH-1:0]     commit_pc,
    output logic [`INSTR_WIDTH-1:0]  commit_instr,
    output logic [`LREG_WIDTH-1:0]   commit_lrd,
    output logic [`PREG_WIDTH-1:0]   commit_prd,
    output logic [`PREG_WIDTH-1:0]   commit_old_prd,
    output logic                     commit_need_to_wb,
    output logic                     commit_skip
);
    import uop_pkg::*;

    rob_ram_if #(.payload_t(instr_info_t))  info_bus ();
    rob_ram_if #(.payload_t(rename_info_t)) rename_bus ();
    rob_status_if                           status_bus ();

    // payload goes straight onto the ram buses
    // the controller steers the slot
    assign info_bus.write_data   = '{pc: enq_pc, instr: enq_instr};
    assign rename_bus.write_data = '{lrd: enq_lrd, prd: enq_prd, old_prd: enq_old_prd,
                                     need_to_wb: enq_need_to_wb};

    rob_commit_ctrl commit_ctrl_u (
        .clock       (clock),
        .reset_n     (reset_n),
        .enq_valid   (enq_valid),
        .enq_ready   (enq_ready),
        .enq_robidx  (enq_robidx),
        .commit_valid(commit_valid),
        .commit_ready(commit_ready),
        .status      (status_bus.ctrl),
        .info_ram    (info_bus.ctrl),
        .rename_ram  (rename_bus.ctrl)
    );

    rob_status_table status_table_u (
        .clock     (clock),
        .reset_n   (reset_n),
        .status    (status_bus.tbl),
        .wb0_valid (wb0_valid),
        .wb0_robidx(wb0_robidx),
        .wb1_valid (wb1_valid),
        .wb1_robidx(wb1_robidx),
        .wb1_mmio  (wb1_mmio)
    );

    rob_payload_ram #(.payload_t(instr_info_t)) info_ram_u (
        .clock(clock),
        .ram  (info_bus.ram)
    );

    rob_payload_ram #(.payload_t(rename_info_t)) rename_ram_u (
        .clock(clock),
        .ram  (rename_bus.ram)
    );

    // head entry fields are meaningful while commit_valid
    assign commit_pc         = info_bus.read_data.pc;
    assign commit_instr      = info_bus.read_data.instr;
    assign commit_lrd        = rename_bus.read_data.lrd;
    assign commit_prd        = rename_bus.read_data.prd;
    assign commit_old_prd    = rename_bus.read_data.old_prd;
    assign commit_need_to_wb = rename_bus.read_data.need_to_wb;
    assign commit_skip       = status_bus.head_skip;

endmodule

/* test/rob_top_props.sv */
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_top_props (
    input logic                                  clock,
    input logic                                  reset_n,
    input logic                                  enq_valid,
    input logic                                  enq_ready,
    input logic                                  commit_valid,
    input logic                                  commit_ready,
    input logic                                  full,
    input rob_pkg::rob_ptr_t                     enq_ptr,
    input logic [`PC_WIDTH+`INSTR_WIDTH-1:0]     info_data,
    input logic [2*`PREG_WIDTH+`LREG_WIDTH:0]    rename_data
);

    // buffer sits empty while reset is held
    reset_empty: assert property (@(posedge clock) !reset_n |-> enq_ready && !commit_valid)
        else $error("buffer not empty during reset");

    // stalled commit keeps its entry and payload
    commit_hold: assert property (@(posedge clock) disable iff (!reset_n)
        commit_valid && !commit_ready |=> commit_valid && $stable(info_data)
            && $stable(rename_data))
        else $error("commit payload changed under back-pressure");

    no_enq_when_full: assert property (@(posedge clock) disable iff (!reset_n)
        full && enq_valid |=> $stable(enq_ptr))
        else $error("enqueue pointer moved while full");

endmodule

bind rob_commit_ctrl rob_top_props props_u (
    .clock       (clock),
    .reset_n     (reset_n),
    .enq_valid   (enq_valid),
    .enq_ready   (enq_ready),
    .commit_valid(commit_valid),
    .commit_ready(commit_ready),
    .full        (full),
    .enq_ptr     (enq_ptr),
    .info_data   (info_ram.read_data),
    .rename_data (rename_ram.read_data)
);

/* test/rob_top_tb.sv */
`timescale 1ns/1ps

module rob_top_tb;

    logic        clock;
    logic        reset_n;
    logic        enq_valid;
    logic        enq_ready;
    logic [63:0] enq_pc;
    logic [31:0] enq_instr;
    logic [4:0]  enq_lrd;
    logic [5:0]  enq_prd;
    logic [5:0]  enq_old_prd;
    logic        enq_need_to_wb;
    logic [2:0]  enq_robidx;
    logic        wb0_valid;
    logic [2:0]  wb0_robidx;
    logic        wb1_valid;
    logic [2:0]  wb1_robidx;
    logic        wb1_mmio;
    logic        commit_valid;
    logic        commit_ready;
    logic [63:0] commit_pc;
    logic [31:0] commit_instr;
    logic [4:0]  commit_lrd;
    logic [5:0]  commit_prd;
    logic [5:0]  commit_old_prd;
    logic        commit_need_to_wb;
    logic        commit_skip;

    int errors;
    int checks;
    int next_idx;
    int n_enq;
    int n_wb;
    int n_ret;

    // one group of instructions from the vector file
    logic [63:0] e_pc [8];
    logic [31:0] e_instr [8];
    logic [4:0]  e_lrd [8];
    logic [5:0]  e_prd [8];
    logic [5:0]  e_old [8];
    logic        e_need [8];
    logic [2:0]  e_idx [8];
    logic [63:0] r_pc [8];
    int          r_skip [8];
    int          w_port [8];
    int          w_ord [8];
    int          w_mmio [8];

    rob_top rob_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic abort_run(string why);
        $display("%s", why);
        $display("checks %0d, errors %0d", checks, errors);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic enqueue_one(int k);
        int wait_cnt;
        wait_cnt = 0;
        @(posedge clock);
        enq_valid      <= 1'b1;
        enq_pc         <= e_pc[k];
        enq_instr      <= e_instr[k];
        enq_lrd        <= e_lrd[k];
        enq_prd        <= e_prd[k];
        enq_old_prd    <= e_old[k];
        enq_need_to_wb <= e_need[k];
        @(negedge clock);
        while (!enq_ready) begin
            wait_cnt++;
            if (wait_cnt > 50) abort_run("timeout waiting for enq_ready");
            @(negedge clock);
        end
        e_idx[k] = enq_robidx;
        check_value("enq_robidx", 64'(next_idx), 64'(enq_robidx));
        next_idx = (next_idx + 1) % 8;
        @(posedge clock);
        enq_valid <= 1'b0;
    endtask

    task automatic write_back(int port, logic [2:0] idx, int mmio);
        @(posedge clock);
        if (port == 0) begin
            wb0_valid  <= 1'b1;
            wb0_robidx <= idx;
        end else begin
            wb1_valid  <= 1'b1;
            wb1_robidx <= idx;
            wb1_mmio   <= 1'(mmio);
        end
        @(posedge clock);
        wb0_valid <= 1'b0;
        wb1_valid <= 1'b0;
        wb1_mmio  <= 1'b0;
    endtask

    task automatic run_group();
        bit          done [8];
        int          retired;
        int          wait_cnt;
        bit          held;
        bit          ready_pending;
        logic [63:0] h_pc;
        logic [31:0] h_instr;
        retired = 0;
        wait_cnt = 0;
        held = 0;
        ready_pending = 0;
        for (int k = 0; k < n_enq; k++) enqueue_one(k);
        if (n_enq == 8) begin
            @(negedge clock);
            check_value("enq_ready when full", 64'(0), 64'(enq_ready));
        end
        // commit held off while writebacks land
        // head completes only with ordinal 0
        for (int k = 0; k < n_wb; k++) begin
            write_back(w_port[k], e_idx[w_ord[k]], w_mmio[k]);
            done[w_ord[k]] = 1;
            @(negedge clock);
            check_value("commit_valid after writeback", 64'(done[0]), 64'(commit_valid));
        end
        while (retired < n_enq) begin
            wait_cnt++;
            if (wait_cnt > 40 * n_enq) abort_run("timeout waiting for retirement");
            @(posedge clock);
            commit_ready <= 1'($urandom % 2);
            @(negedge clock);
            if (ready_pending) begin
                check_value("enq_ready after retire", 64'(1), 64'(enq_ready));
                ready_pending = 0;
            end
            if (held) begin
                check_value("held commit_valid", 64'(1), 64'(commit_valid));
                check_value("held commit_pc", h_pc, commit_pc);
                check_value("held commit_instr", 64'(h_instr), 64'(commit_instr));
            end
            held = 0;
            if (commit_valid && commit_ready) begin
                check_value("commit_pc", r_pc[retired], commit_pc);
                check_value("commit_skip", 64'(r_skip[retired]), 64'(commit_skip));
                check_value("commit_instr", 64'(e_instr[retired]), 64'(commit_instr));
                check_value("commit_lrd", 64'(e_lrd[retired]), 64'(commit_lrd));
                check_value("commit_prd", 64'(e_prd[retired]), 64'(commit_prd));
                check_value("commit_old_prd", 64'(e_old[retired]), 64'(commit_old_prd));
                check_value("commit_need_to_wb", 64'(e_need[retired]),
                            64'(commit_need_to_wb));
                retired++;
                if (retired == 1 && n_enq == 8) ready_pending = 1;
            end else if (commit_valid) begin
                held = 1;
                h_pc = commit_pc;
                h_instr = commit_instr;
            end
        end
        @(posedge clock);
        commit_ready <= 1'b0;
        @(negedge clock);
        check_value("commit_valid after drain", 64'(0), 64'(commit_valid));
        n_enq = 0;
        n_wb = 0;
        n_ret = 0;
    endtask

    initial begin
        int          fd;
        int          code;
        string       line;
        byte         kind;
        logic [63:0] f0;
        logic [63:0] f1;
        logic [63:0] f2;
        logic [63:0] f3;
        logic [63:0] f4;
        logic [63:0] f5;
        void'($urandom(32'h717c));
        errors = 0;
        checks = 0;
        next_idx = 0;
        n_enq = 0;
        n_wb = 0;
        n_ret = 0;
        reset_n = 1'b0;
        enq_valid = 1'b0;
        enq_pc = '0;
        enq_instr = '0;
        enq_lrd = '0;
        enq_prd = '0;
        enq_old_prd = '0;
        enq_need_to_wb = 1'b0;
        wb0_valid = 1'b0;
        wb0_robidx = '0;
        wb1_valid = 1'b0;
        wb1_robidx = '0;
        wb1_mmio = 1'b0;
        commit_ready = 1'b0;
        repeat (16) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        check_value("reset enq_ready", 64'(1), 64'(enq_ready));
        check_value("reset commit_valid", 64'(0), 64'(commit_valid));
        check_value("reset enq_robidx", 64'(0), 64'(enq_robidx));
        fd = $fopen("test/rob_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open test/rob_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code == 0 || line.len() < 1) continue;
                kind = line.getc(0);
                if (kind == "E") begin
                    code = $sscanf(line, "E %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
                    e_pc[n_enq] = f0;
                    e_instr[n_enq] = f1[31:0];
                    e_lrd[n_enq] = f2[4:0];
                    e_prd[n_enq] = f3[5:0];
                    e_old[n_enq] = f4[5:0];
                    e_need[n_enq] = f5[0];
                    n_enq++;
                end else if (kind == "W") begin
                    code = $sscanf(line, "W %d %d %d",
                                   w_port[n_wb], w_ord[n_wb], w_mmio[n_wb]);
                    n_wb++;
                end else if (kind == "R") begin
                    code = $sscanf(line, "R %h %d", f0, r_skip[n_ret]);
                    r_pc[n_ret] = f0;
                    n_ret++;
                end else if (kind == "G") begin
                    run_group();
                end
            end
            $fclose(fd);
            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

/* rob_lite.f */
+incdir+verilog
verilog/uop_pkg.sv
verilog/rob_pkg.sv
verilog/rob_ifs.sv
verilog/rob_payload_ram.sv
verilog/rob_status_table.sv
verilog/rob_commit_ctrl.sv
verilog/rob_top.sv
test/rob_top_props.sv
test/rob_top_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only --timing
TOP       := rob_top_tb
FILELIST  := rob_lite.f
PASS_MSG  := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* test/rob_vectors.txt */
# E pc instr lrd prd old_prd need_to_wb (hex) | W port ordinal mmio
# R pc skip in expected retire order | G runs the lines above as one group
E 80000000 00a00093 01 21 01 1
E 80000004 0000a103 02 22 02 1
E 80000008 00208233 04 23 04 1
W 0 2 0
W 1 1 1
W 1 0 0
R 80000000 0
R 80000004 1
R 80000008 0
G
E 8000000c 00110113 02 24 22 1
E 80000010 0020a023 00 00 00 0
E 80000014 00c12183 03 25 03 1
E 80000018 40418233 04 26 23 1
E 8000001c 0001a283 05 27 05 1
E 80000020 00628333 06 28 06 1
E 80000024 0002a383 07 29 07 1
E 80000028 fe000ee3 00 00 00 0
W 0 1 0
W 1 2 0
W 0 3 0
W 1 4 1
W 0 5 0
W 1 6 1
W 0 7 0
W 0 0 0
R 8000000c 0
R 80000010 0
R 80000014 0
R 80000018 0
R 8000001c 1
R 80000020 0
R 80000024 1
R 80000028 0
G
